//--- twiddle.hex
// columns: cos (high 16 bits) then sin (low 16 bits), angle 2*pi*i/64, 1.0 = 4000
40000000
3FB10646
3EC50C7C
3D3F1294
3B21187E
38711E2B
3537238E
3179289A
2D412D41
289A3179
238E3537
1E2B3871
187E3B21
12943D3F
0C7C3EC5
06463FB1
00004000

//--- src.f
+incdir+logic
logic/fft_pkg.sv
logic/fft_ifs.sv
logic/fft_sequencer.sv
logic/fft_fetch.sv
logic/fft_twiddle.sv
logic/fft_butterfly.sv
logic/fft_writeback.sv
logic/fft_top.sv
verif/tb_clock.sv
verif/tb_fft.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f src.f --top-module tb_fft -o sim_tb_fft

out=$(./obj_dir/sim_tb_fft 2>&1) || true
echo "$out"

# pass only when the testbench printed its pass line
echo "$out" | grep -qx "NO ERRORS"

//--- verif/tb_fft.sv
`include "fft_defs.svh"

module tb_fft;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int AW      = `FFT_ADDR_W;
    localparam int DEPTH   = 1 << AW;
    localparam int TW_BITS = `FFT_LOG_MAX - 1;
    localparam int QUART   = `FFT_TAB_LEN - 1;
    localparam int MAX_WAIT = 4000;

    logic           gated_clk;
    logic           rst_n;
    logic           start_i;
    logic           ifft_i;
    logic [2:0]     fft_n_i;
    logic           busy_o;
    logic           result_in_b_o;
    logic [AW-1:0]  buf_a_raddr, buf_a_waddr, buf_b_raddr, buf_b_waddr;
    logic           buf_a_re, buf_a_we, buf_b_re, buf_b_we;
    logic [31:0]    buf_a_rdata = '0;
    logic [31:0]    buf_b_rdata = '0;
    logic [31:0]    buf_a_wdata, buf_b_wdata;
    logic           load_en;
    logic [AW-1:0]  load_addr;
    logic [31:0]    load_data;
    logic [15:0]    lfsr;
    logic [31:0]    mem_a [DEPTH];
    logic [31:0]    mem_b [DEPTH];
    logic [31:0]    ref_mem [DEPTH];
    logic [31:0]    tw_tab [`FFT_TAB_LEN];

    tb_clock i_clock (.clk_o(gated_clk), .rst_n_o(rst_n));

    fft_top i_fft_top (
        .gated_clk     (gated_clk),
        .rst_n         (rst_n),
        .start_i       (start_i),
        .ifft_i        (ifft_i),
        .fft_n_i       (fft_n_i),
        .busy_o        (busy_o),
        .result_in_b_o (result_in_b_o),
        .buf_a_raddr_o (buf_a_raddr),
        .buf_a_re_o    (buf_a_re),
        .buf_a_rdata_i (buf_a_rdata),
        .buf_a_waddr_o (buf_a_waddr),
        .buf_a_we_o    (buf_a_we),
        .buf_a_wdata_o (buf_a_wdata),
        .buf_b_raddr_o (buf_b_raddr),
        .buf_b_re_o    (buf_b_re),
        .buf_b_rdata_i (buf_b_rdata),
        .buf_b_waddr_o (buf_b_waddr),
        .buf_b_we_o    (buf_b_we),
        .buf_b_wdata_o (buf_b_wdata)
    );

    // **********************************************************************
    // dual-port buffers, one-cycle read latency
    // **********************************************************************
    always @(posedge gated_clk) begin
        if (load_en) begin
            mem_a[load_addr] <= load_data;      // preload port
        end else if (buf_a_we) begin
            mem_a[buf_a_waddr] <= buf_a_wdata;
        end
        if (buf_b_we) mem_b[buf_b_waddr] <= buf_b_wdata;
        if (buf_a_re) buf_a_rdata <= mem_a[buf_a_raddr];
        if (buf_b_re) buf_b_rdata <= mem_b[buf_b_raddr];
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic random_sample(output int val);
        val = 0;
        for (int i = 0; i < 14; i++) begin
            lfsr = lfsr_next(lfsr);
            val  = (val << 1) | int'(lfsr[0]);
        end
        if (val >= 8192) val -= 16384;  // signed, within +-2^13
    endtask

    function automatic int bit_reverse(input int v, input int nbits);
        int r;
        r = 0;
        for (int i = 0; i < nbits; i++) r = (r << 1) | ((v >> i) & 1);
        return r;
    endfunction

    function automatic logic [15:0] half_round(input int s);
        int t;
        t = (s + 1) >>> 1;
        return t[15:0];
    endfunction

    // cos in the real part, sin negated for the forward transform
    function automatic logic [31:0] twiddle_word(input int idx, input bit inv);
        int c;
        int s;
        logic [31:0] e;
        if (idx > QUART) begin
            e = tw_tab[idx - QUART];
            c = -$signed(e[15:0]);
            s = $signed(e[31:16]);
        end else begin
            e = tw_tab[idx];
            c = $signed(e[31:16]);
            s = $signed(e[15:0]);
        end
        if (!inv) s = -s;
        return {16'(s), 16'(c)};
    endfunction

    task automatic butterfly(input logic [31:0] wa, wb, ww, output logic [31:0] wp, wq);
        int ar, ai, br, bi, cr, ci, mr, mi;
        logic signed [15:0] m_re;
        logic signed [15:0] m_im;
        ar = $signed(wa[15:0]);
        ai = $signed(wa[31:16]);
        br = $signed(wb[15:0]);
        bi = $signed(wb[31:16]);
        cr = $signed(ww[15:0]);
        ci = $signed(ww[31:16]);
        mr = br * cr - bi * ci;
        mi = br * ci + bi * cr;
        m_re = 16'(mr >>> `FFT_TW_FRAC);
        m_im = 16'(mi >>> `FFT_TW_FRAC);
        wp = {half_round(ai + m_im), half_round(ar + m_re)};
        wq = {half_round(ai - m_im), half_round(ar - m_re)};
    endtask

    // in-place passes then bit-reversed copy, result back in ref_mem
    task automatic compute_reference(input int n, input bit inv);
        logic [31:0] cur [DEPTH];
        logic [31:0] nxt [DEPTH];
        int half, a, tw;
        cur = ref_mem;
        for (int s = 0; s < n; s++) begin
            half = 1 << (n - 1 - s);
            for (int g = 0; g < (1 << s); g++) begin
                tw = bit_reverse(g, s) << (TW_BITS - s);
                for (int k = 0; k < half; k++) begin
                    a = (g << (n - s)) + k;
                    butterfly(cur[a], cur[a + half], twiddle_word(tw, inv), nxt[a],
                              nxt[a + half]);
                end
            end
            cur = nxt;
        end
        for (int i = 0; i < (1 << n); i++) ref_mem[i] = cur[bit_reverse(i, n)];
    endtask

    task automatic preload_buffer(input int n, input bit impulse);
        int v_re, v_im;
        logic [31:0] w;
        for (int i = 0; i < (1 << n); i++) begin
            if (impulse) begin
                w = (i == 0) ? 32'h0000_1fff : 32'h0;
            end else begin
                random_sample(v_re);
                random_sample(v_im);
                w = {16'(v_im), 16'(v_re)};
            end
            ref_mem[i] = w;
            @(posedge gated_clk);
            load_en   <= 1'b1;
            load_addr <= AW'(i);
            load_data <= w;
        end
        @(posedge gated_clk);
        load_en <= 1'b0;
    endtask

    task automatic run_transform(input int n, input bit inv, input bit impulse,
                                 input bit restart);
        int cnt;
        logic [31:0] got;
        preload_buffer(n, impulse);
        compute_reference(n, inv);
        @(posedge gated_clk);
        start_i <= 1'b1;
        fft_n_i <= 3'(n);
        ifft_i  <= inv;
        @(posedge gated_clk);
        start_i <= 1'b0;
        @(negedge gated_clk);
        assert (busy_o === 1'b1) else begin
            $display("busy_o did not rise in the cycle after start_i");
            $display("ERRORS FOUND");
            $fatal(1);
        end
        if (restart) begin
            repeat (7) @(posedge gated_clk);
            start_i <= 1'b1;        // must be ignored
            fft_n_i <= 3'd6;
            @(posedge gated_clk);
            start_i <= 1'b0;
        end
        cnt = 0;
        while (busy_o !== 1'b0) begin
            @(negedge gated_clk);
            cnt++;
            if (cnt > MAX_WAIT) begin
                $display("timeout while waiting for busy_o to fall");
                $display("ERRORS FOUND");
                $fatal(1);
            end
        end
        assert (result_in_b_o === (n % 2 == 0)) else begin
            $display("mismatch result_in_b_o: got %h expected %h", result_in_b_o, n % 2 == 0);
            $display("ERRORS FOUND");
            $fatal(1);
        end
        for (int i = 0; i < (1 << n); i++) begin
            got = result_in_b_o ? mem_b[i] : mem_a[i];
            assert (got === ref_mem[i]) else begin
                $display("mismatch buf_%s[%0d]: got %h expected %h",
                         result_in_b_o ? "b" : "a", i, got, ref_mem[i]);
                $display("ERRORS FOUND");
                $fatal(1);
            end
        end
        if (restart) begin
            repeat (3) begin
                @(negedge gated_clk);
                assert (busy_o === 1'b0) else begin
                    $display("a second transform started after the ignored start_i");
                    $display("ERRORS FOUND");
                    $fatal(1);
                end
            end
        end
    endtask

    initial begin
        int cnt;
        start_i   <= 1'b0;
        ifft_i    <= 1'b0;
        fft_n_i   <= 3'd2;
        load_en   <= 1'b0;
        load_addr <= '0;
        load_data <= '0;
        lfsr = 16'd49411;
        $readmemh("twiddle.hex", tw_tab);
        cnt = 0;
        while (rst_n !== 1'b1) begin
            @(negedge gated_clk);
            cnt++;
            if (cnt > 20) begin
                $display("timeout while waiting for reset release");
                $display("ERRORS FOUND");
                $fatal(1);
            end
        end
        repeat (3) begin
            @(negedge gated_clk);
            assert (busy_o === 1'b0 && buf_a_we === 1'b0 && buf_b_we === 1'b0 &&
                    buf_a_re === 1'b0 && buf_b_re === 1'b0) else begin
                $display("busy_o or a read or write enable is not low after reset");
                $display("ERRORS FOUND");
                $fatal(1);
            end
        end
        for (int n = 2; n <= `FFT_LOG_MAX; n++) run_transform(n, 1'b0, 1'b0, 1'b0);
        run_transform(5, 1'b1, 1'b0, 1'b0);     // inverse, odd and even n
        run_transform(4, 1'b1, 1'b0, 1'b0);
        run_transform(6, 1'b0, 1'b1, 1'b0);     // impulse
        run_transform(3, 1'b0, 1'b1, 1'b0);
        run_transform(4, 1'b0, 1'b0, 1'b1);     // start while busy
        $display("NO ERRORS");
        $finish;
    end

endmodule

//--- verif/tb_clock.sv
module tb_clock (
    output logic clk_o,
    output logic rst_n_o
);

    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk_o = 1'b0;
        forever #50 clk_o = ~clk_o;     // 100 ns period
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (5) @(posedge clk_o);
        rst_n_o <= 1'b1;
    end

endmodule

//--- logic/fft_top.sv
`include "fft_defs.svh"

module fft_top (
    input  logic                    gated_clk,
    input  logic                    rst_n,
    input  logic                    start_i,
    input  logic                    ifft_i,
    input  logic [2:0]              fft_n_i,
    output logic                    busy_o,
    output logic                    result_in_b_o,
    output logic [`FFT_ADDR_W-1:0]  buf_a_raddr_o,
    output logic                    buf_a_re_o,
    input  logic [2*`FFT_W-1:0]     buf_a_rdata_i,
    output logic [`FFT_ADDR_W-1:0]  buf_a_waddr_o,
    output logic                    buf_a_we_o,
    output logic [2*`FFT_W-1:0]     buf_a_wdata_o,
    output logic [`FFT_ADDR_W-1:0]  buf_b_raddr_o,
    output logic                    buf_b_re_o,
    input  logic [2*`FFT_W-1:0]     buf_b_rdata_i,
    output logic [`FFT_ADDR_W-1:0]  buf_b_waddr_o,
    output logic                    buf_b_we_o,
    output logic [2*`FFT_W-1:0]     buf_b_wdata_o
);

    logic done;

    fft_issue_if  issue_if ();
    fft_pair_if   fetch_pair_if ();   // tw holds the table index here
    fft_pair_if   tw_pair_if ();
    fft_result_if result_if ();

    fft_sequencer i_sequencer (
        .gated_clk     (gated_clk),
        .rst_n         (rst_n),
        .start_i       (start_i),
        .fft_n_i       (fft_n_i),
        .done_i        (done),
        .busy_o        (busy_o),
        .result_in_b_o (result_in_b_o),
        .issue         (issue_if)
    );

    fft_fetch i_fetch (
        .gated_clk     (gated_clk),
        .rst_n         (rst_n),
        .issue         (issue_if),
        .buf_a_raddr_o (buf_a_raddr_o),
        .buf_a_re_o    (buf_a_re_o),
        .buf_a_rdata_i (buf_a_rdata_i),
        .buf_b_raddr_o (buf_b_raddr_o),
        .buf_b_re_o    (buf_b_re_o),
        .buf_b_rdata_i (buf_b_rdata_i),
        .pair          (fetch_pair_if)
    );

    fft_twiddle i_twiddle (
        .gated_clk (gated_clk),
        .rst_n     (rst_n),
        .ifft_i    (ifft_i),
        .pair_in   (fetch_pair_if),
        .pair_out  (tw_pair_if)
    );

    fft_butterfly i_butterfly (
        .gated_clk (gated_clk),
        .rst_n     (rst_n),
        .pair      (tw_pair_if),
        .result    (result_if)
    );

    fft_writeback i_writeback (
        .gated_clk     (gated_clk),
        .rst_n         (rst_n),
        .result        (result_if),
        .buf_a_waddr_o (buf_a_waddr_o),
        .buf_a_we_o    (buf_a_we_o),
        .buf_a_wdata_o (buf_a_wdata_o),
        .buf_b_waddr_o (buf_b_waddr_o),
        .buf_b_we_o    (buf_b_we_o),
        .buf_b_wdata_o (buf_b_wdata_o),
        .done_o        (done)
    );

endmodule

//--- logic/fft_writeback.sv
`include "fft_defs.svh"

module fft_writeback (
    input  logic                    gated_clk,
    input  logic                    rst_n,
    fft_result_if.sink              result,
    output logic [`FFT_ADDR_W-1:0]  buf_a_waddr_o,
    output logic                    buf_a_we_o,
    output logic [2*`FFT_W-1:0]     buf_a_wdata_o,
    output logic [`FFT_ADDR_W-1:0]  buf_b_waddr_o,
    output logic                    buf_b_we_o,
    output logic [2*`FFT_W-1:0]     buf_b_wdata_o,
    output logic                    done_o
);

    import fft_pkg::*;

    localparam int AW = `FFT_ADDR_W;

    logic           wr_en;
    logic           wr_b;
    logic           q_pend;     // q goes out the cycle after p
    logic           copy_wr;
    logic [AW-1:0]  waddr;
    logic [AW-1:0]  q_addr;
    cplx_word_u     wdata;
    cplx_word_u     q_data;

    assign buf_a_we_o    = wr_en & ~wr_b;
    assign buf_b_we_o    = wr_en & wr_b;
    assign buf_a_waddr_o = waddr;
    assign buf_b_waddr_o = waddr;
    assign buf_a_wdata_o = wdata;
    assign buf_b_wdata_o = wdata;

    always_ff @(posedge gated_clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_en   <= 1'b0;
            q_pend  <= 1'b0;
            copy_wr <= 1'b0;
            done_o  <= 1'b0;
        end else begin
            wr_en   <= result.valid | q_pend;
            q_pend  <= result.valid & ~result.copy;
            copy_wr <= result.valid & result.copy;
            // copy writes come back to back, the first gap ends the pass
            done_o  <= copy_wr & ~(result.valid & result.copy);
        end
    end

    always_ff @(posedge gated_clk) begin
        if (result.valid) begin
            wr_b   <= result.dst_b;
            waddr  <= result.wr_addr[AW-1:0];
            wdata  <= result.res_p;
            q_addr <= result.wr_addr[AW-1:0] + result.wr_addr[2*AW-1:AW];
            q_data <= result.res_q;
        end else begin
            waddr  <= q_addr;
            wdata  <= q_data;
        end
    end

    // issue spacing upstream keeps results away from a pending q
    a_no_overrun: assert property (@(posedge gated_clk) disable iff (!rst_n)
        result.valid |-> !q_pend);

endmodule

//--- logic/fft_butterfly.sv
`include "fft_defs.svh"

module fft_butterfly (
    input  logic          gated_clk,
    input  logic          rst_n,
    fft_pair_if.sink      pair,
    fft_result_if.source  result
);

    import fft_pkg::*;

    localparam int W  = `FFT_W;
    localparam int AW = `FFT_ADDR_W;

    logic signed [2*W:0]  mul_re;
    logic signed [2*W:0]  mul_im;
    logic signed [W-1:0]  prod_re;
    logic signed [W-1:0]  prod_im;
    logic signed [W:0]    p_re;
    logic signed [W:0]    p_im;
    logic signed [W:0]    q_re;
    logic signed [W:0]    q_im;
    logic                 s1_vld;
    logic                 s1_copy;
    logic                 s1_dst_b;
    logic [2*AW-1:0]      s1_wr_addr;
    cplx_word_u           s1_a;

    // (s + 1) >>> 1, kept to W bits
    function automatic logic signed [W-1:0] half_rnd(input logic signed [W:0] s);
        logic [W+1:0] t;
        t = {s[W], s} + 1'b1;
        return t[W:1];
    endfunction

    assign mul_re = pair.op_b.s.re * pair.tw.s.re - pair.op_b.s.im * pair.tw.s.im;
    assign mul_im = pair.op_b.s.re * pair.tw.s.im + pair.op_b.s.im * pair.tw.s.re;

    assign p_re = s1_a.s.re + prod_re;
    assign p_im = s1_a.s.im + prod_im;
    assign q_re = s1_a.s.re - prod_re;
    assign q_im = s1_a.s.im - prod_im;

    always_ff @(posedge gated_clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_vld       <= 1'b0;
            result.valid <= 1'b0;
        end else begin
            s1_vld       <= pair.valid;
            result.valid <= s1_vld;
        end
    end

    always_ff @(posedge gated_clk) begin
        // stage 1, product back to sample scale
        prod_re    <= W'(mul_re >>> `FFT_TW_FRAC);
        prod_im    <= W'(mul_im >>> `FFT_TW_FRAC);
        s1_a       <= pair.op_a;
        s1_copy    <= pair.copy;
        s1_dst_b   <= pair.dst_b;
        s1_wr_addr <= pair.wr_addr;
        // stage 2, sum and difference halved
        result.copy    <= s1_copy;
        result.dst_b   <= s1_dst_b;
        result.wr_addr <= s1_wr_addr;
        result.res_q.s.re <= half_rnd(q_re);
        result.res_q.s.im <= half_rnd(q_im);
        if (s1_copy) begin
            result.res_p <= s1_a;     // copy word untouched
        end else begin
            result.res_p.s.re <= half_rnd(p_re);
            result.res_p.s.im <= half_rnd(p_im);
        end
    end

endmodule

//--- logic/fft_twiddle.sv
`include "fft_defs.svh"

module fft_twiddle (
    input  logic        gated_clk,
    input  logic        rst_n,
    input  logic        ifft_i,
    fft_pair_if.sink    pair_in,
    fft_pair_if.source  pair_out
);

    import fft_pkg::*;

    localparam int TW     = `FFT_LOG_MAX - 1;
    localparam int TAB_AW = $clog2(`FFT_TAB_LEN);
    localparam int QUART  = `FFT_TAB_LEN - 1;   // index of pi/2

    logic [2*`FFT_W-1:0]      tab [`FFT_TAB_LEN];
    logic [TW-1:0]            idx;
    logic                     fold;
    logic [TAB_AW-1:0]        tab_addr;
    cplx_word_u               entry;
    cplx_word_u               tw_word;
    logic signed [`FFT_W-1:0] cos_v;
    logic signed [`FFT_W-1:0] sin_v;

    initial begin
        $readmemh("twiddle.hex", tab);
    end

    assign idx      = pair_in.tw[TW-1:0];
    assign fold     = idx > TW'(QUART);     // second quadrant
    assign tab_addr = fold ? TAB_AW'(idx - TW'(QUART)) : TAB_AW'(idx);
    assign entry    = tab[tab_addr];

    // cos(pi/2 + x) = -sin x, sin(pi/2 + x) = cos x
    assign cos_v = fold ? -entry.t.sin : entry.t.cos;
    assign sin_v = fold ? entry.t.cos : entry.t.sin;

    always_comb begin
        tw_word.s.re = cos_v;
        tw_word.s.im = ifft_i ? sin_v : -sin_v;   // e^-j for the forward transform
    end

    always_ff @(posedge gated_clk or negedge rst_n) begin
        if (!rst_n) begin
            pair_out.valid <= 1'b0;
        end else begin
            pair_out.valid <= pair_in.valid;
        end
    end

    always_ff @(posedge gated_clk) begin
        pair_out.copy    <= pair_in.copy;
        pair_out.dst_b   <= pair_in.dst_b;
        pair_out.wr_addr <= pair_in.wr_addr;
        pair_out.op_a    <= pair_in.op_a;
        pair_out.op_b    <= pair_in.op_b;
        pair_out.tw      <= tw_word;
    end

endmodule

//--- logic/fft_fetch.sv
`include "fft_defs.svh"

module fft_fetch (
    input  logic                    gated_clk,
    input  logic                    rst_n,
    fft_issue_if.sink               issue,
    output logic [`FFT_ADDR_W-1:0]  buf_a_raddr_o,
    output logic                    buf_a_re_o,
    input  logic [2*`FFT_W-1:0]     buf_a_rdata_i,
    output logic [`FFT_ADDR_W-1:0]  buf_b_raddr_o,
    output logic                    buf_b_re_o,
    input  logic [2*`FFT_W-1:0]     buf_b_rdata_i,
    fft_pair_if.source              pair
);

    import fft_pkg::*;

    localparam int AW = `FFT_ADDR_W;
    localparam int TW = `FFT_LOG_MAX - 1;

    logic           vld_d;
    logic           second_d;
    logic           copy_d;
    logic           src_b_d;
    logic [AW-1:0]  rd_addr_d;
    logic [AW-1:0]  wr_addr_d;
    logic [AW-1:0]  a_wr_hold;
    logic [TW-1:0]  tw_idx_d;
    cplx_word_u     rd_word;
    cplx_word_u     a_hold;

    assign buf_a_raddr_o = issue.rd_addr;
    assign buf_b_raddr_o = issue.rd_addr;
    assign buf_a_re_o    = issue.valid & ~issue.src_b;
    assign buf_b_re_o    = issue.valid & issue.src_b;

    assign rd_word = src_b_d ? buf_b_rdata_i : buf_a_rdata_i;

    always_ff @(posedge gated_clk or negedge rst_n) begin
        if (!rst_n) begin
            vld_d      <= 1'b0;
            pair.valid <= 1'b0;
        end else begin
            vld_d      <= issue.valid;
            pair.valid <= vld_d & (second_d | copy_d);   // a alone never goes out
        end
    end

    // item fields follow the one-cycle read latency
    always_ff @(posedge gated_clk) begin
        second_d  <= issue.second;
        copy_d    <= issue.copy;
        src_b_d   <= issue.src_b;
        rd_addr_d <= issue.rd_addr;
        wr_addr_d <= issue.wr_addr;
        tw_idx_d  <= issue.tw_idx;
        if (vld_d && !second_d && !copy_d) begin
            a_hold    <= rd_word;
            a_wr_hold <= wr_addr_d;
        end
        if (vld_d && (second_d || copy_d)) begin
            pair.copy  <= copy_d;
            pair.dst_b <= ~src_b_d;
            pair.op_a  <= copy_d ? rd_word : a_hold;
            pair.op_b  <= rd_word;
            // step is the distance from a to b, zero for a copy
            pair.wr_addr <= copy_d ? {AW'(0), wr_addr_d} :
                                     {rd_addr_d - a_wr_hold, a_wr_hold};
            pair.tw      <= {{(2*`FFT_W-TW){1'b0}}, tw_idx_d};
        end
    end

    // a b read always follows its a read on the same buffer
    a_b_follows_a: assert property (@(posedge gated_clk) disable iff (!rst_n)
        (issue.valid && issue.second) |->
            ($past(issue.valid && !issue.second && !issue.copy) &&
             $past(issue.src_b) == issue.src_b));

endmodule

//--- logic/fft_sequencer.sv
`include "fft_defs.svh"

module fft_sequencer (
    input  logic        gated_clk,
    input  logic        rst_n,
    input  logic        start_i,
    input  logic [2:0]  fft_n_i,
    input  logic        done_i,
    output logic        busy_o,
    output logic        result_in_b_o,
    fft_issue_if.source issue
);

    localparam int AW = `FFT_ADDR_W;
    localparam int DW = $clog2(`FFT_DRAIN + 1);

    localparam logic [2:0] ST_IDLE  = 3'd0;
    localparam logic [2:0] ST_PASS  = 3'd1;
    localparam logic [2:0] ST_DRAIN = 3'd2;
    localparam logic [2:0] ST_COPY  = 3'd3;
    localparam logic [2:0] ST_FINAL = 3'd4;

    logic [2:0]     state;
    logic [2:0]     n_q;
    logic [2:0]     stage;      // loop0
    logic [AW-2:0]  grp;        // loop1
    logic [AW-2:0]  bfly;       // loop2
    logic           second;
    logic           src_b;
    logic [DW-1:0]  drain_cnt;
    logic [AW-1:0]  copy_idx;
    logic [AW-1:0]  a_addr;
    logic [AW-1:0]  half;
    logic [AW-1:0]  rev_full;
    logic [AW-2:0]  grp_rev;
    logic           in_copy;
    logic           grp_last;
    logic           bfly_last;
    logic           stage_last;
    logic           copy_last;

    // group base plus butterfly offset, b sits half a span above
    assign a_addr = ({1'b0, grp} << (n_q - stage)) + {1'b0, bfly};
    assign half   = AW'(1) << (n_q - 3'd1 - stage);

    assign grp_last   = grp == (AW-1)'((AW'(1) << stage) - AW'(1));
    assign bfly_last  = {1'b0, bfly} == half - AW'(1);
    assign stage_last = stage == n_q - 3'd1;
    assign copy_last  = copy_idx == (AW'(1) << n_q) - AW'(1);

    always_comb begin
        for (int i = 0; i < AW; i++) begin
            rev_full[i] = copy_idx[AW-1-i];
        end
        for (int i = 0; i < AW-1; i++) begin
            grp_rev[i] = grp[AW-2-i];   // bit-reversed group gives the twiddle
        end
    end

    assign in_copy       = state == ST_COPY;
    assign issue.valid   = (state == ST_PASS) || in_copy;
    assign issue.copy    = in_copy;
    assign issue.second  = second;
    assign issue.src_b   = src_b;
    assign issue.tw_idx  = grp_rev;
    assign issue.wr_addr = in_copy ? copy_idx : a_addr;
    assign issue.rd_addr = in_copy ? (rev_full >> (AW - n_q)) :
                           (second ? a_addr + half : a_addr);

    always_ff @(posedge gated_clk or negedge rst_n) begin
        if (!rst_n) begin
            state         <= ST_IDLE;
            busy_o        <= 1'b0;
            result_in_b_o <= 1'b0;
            n_q           <= '0;
            stage         <= '0;
            grp           <= '0;
            bfly          <= '0;
            second        <= 1'b0;
            src_b         <= 1'b0;
            drain_cnt     <= '0;
            copy_idx      <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (start_i) begin
                        busy_o        <= 1'b1;
                        result_in_b_o <= ~fft_n_i[0];   // n+1 passes, even n ends in b
                        n_q           <= fft_n_i;
                        stage         <= '0;
                        grp           <= '0;
                        bfly          <= '0;
                        second        <= 1'b0;
                        src_b         <= 1'b0;
                        copy_idx      <= '0;
                        state         <= ST_PASS;
                    end
                end
                ST_PASS: begin
                    second <= ~second;
                    if (second) begin
                        bfly <= bfly_last ? '0 : bfly + 1'b1;
                        if (bfly_last) begin
                            grp <= grp_last ? '0 : grp + 1'b1;
                            if (grp_last) begin
                                drain_cnt <= DW'(`FFT_DRAIN - 1);
                                state     <= ST_DRAIN;
                            end
                        end
                    end
                end
                ST_DRAIN: begin
                    drain_cnt <= drain_cnt - 1'b1;
                    if (drain_cnt == '0) begin
                        src_b <= ~src_b;        // ping-pong
                        stage <= stage + 1'b1;
                        state <= stage_last ? ST_COPY : ST_PASS;
                    end
                end
                ST_COPY: begin
                    copy_idx <= copy_idx + 1'b1;
                    if (copy_last) begin
                        state <= ST_FINAL;
                    end
                end
                ST_FINAL: begin
                    if (done_i) begin
                        busy_o <= 1'b0;
                        state  <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    a_start_n_range: assert property (@(posedge gated_clk) disable iff (!rst_n)
        (state == ST_IDLE && start_i) |-> (fft_n_i >= 3'd2 && fft_n_i <= `FFT_LOG_MAX));

endmodule

//--- logic/fft_ifs.sv
`include "fft_defs.svh"

// **********************************************************************
// sequencer -> fetch, one buffer read per item
// **********************************************************************
interface fft_issue_if;
    logic                      valid;
    logic [`FFT_ADDR_W-1:0]    rd_addr;
    logic                      second;   // b operand read
    logic                      copy;     // bit-reverse pass
    logic                      src_b;
    logic [`FFT_ADDR_W-1:0]    wr_addr;
    logic [`FFT_LOG_MAX-2:0]   tw_idx;   // 64-step scale

    modport source (output valid, rd_addr, second, copy, src_b, wr_addr, tw_idx);
    modport sink   (input  valid, rd_addr, second, copy, src_b, wr_addr, tw_idx);
endinterface

// **********************************************************************
// operand pair, fetch -> twiddle and twiddle -> butterfly
// **********************************************************************
interface fft_pair_if;
    import fft_pkg::*;

    logic                      valid;
    logic                      copy;
    logic                      dst_b;
    logic [2*`FFT_ADDR_W-1:0]  wr_addr;  // {step to q, p address}
    cplx_word_u                op_a;
    cplx_word_u                op_b;
    cplx_word_u                tw;       // table index before the twiddle stage

    modport source (output valid, copy, dst_b, wr_addr, op_a, op_b, tw);
    modport sink   (input  valid, copy, dst_b, wr_addr, op_a, op_b, tw);
endinterface

// **********************************************************************
// butterfly -> writeback
// **********************************************************************
interface fft_result_if;
    import fft_pkg::*;

    logic                      valid;
    logic                      copy;
    logic                      dst_b;
    logic [2*`FFT_ADDR_W-1:0]  wr_addr;
    cplx_word_u                res_p;
    cplx_word_u                res_q;

    modport source (output valid, copy, dst_b, wr_addr, res_p, res_q);
    modport sink   (input  valid, copy, dst_b, wr_addr, res_p, res_q);
endinterface

//--- logic/fft_pkg.sv
`include "fft_defs.svh"

package fft_pkg;

    // buffer sample or table entry, same 32 bits
    typedef union packed {
        struct packed {
            logic signed [`FFT_W-1:0] im;
            logic signed [`FFT_W-1:0] re;
        } s;
        struct packed {
            logic signed [`FFT_W-1:0] cos;
            logic signed [`FFT_W-1:0] sin;
        } t;
    } cplx_word_u;

endpackage

//--- logic/fft_defs.svh
`ifndef FFT_DEFS_SVH
`define FFT_DEFS_SVH

// sample and buffer geometry
`define FFT_W        16
`define FFT_LOG_MAX  6
`define FFT_ADDR_W   6

// quarter-wave table, angles 2*pi*i/64 for i = 0..16
`define FFT_TAB_LEN  17
`define FFT_TW_FRAC  14   // 1.0 == 2**14

// idle cycles after a pass until its last q write has landed
`define FFT_DRAIN    10

`endif
